// ==== logic/la_sys_pkg.sv ====
/*
  Shared bus widths and types, region and analyzer enums,
  stub answer word and register word offsets
*/
`default_nettype none

package la_sys_pkg;

  // Host bus geometry
  localparam int unsigned BUS_AW = 18;
  localparam int unsigned BUS_DW = 32;
  localparam int unsigned REG_N  = 16;

  typedef logic [BUS_AW-1:0] bus_addr_t;
  typedef logic [12-1:0]     bus_off_t;
  typedef logic [BUS_DW-1:0] bus_data_t;

  // Expansion samples and time stamps
  localparam int unsigned SMP_W = 8;
  localparam int unsigned TS_W  = 64;

  typedef logic [SMP_W-1:0] smp_t;
  typedef logic [TS_W-1:0]  ts_t;

  // Regions, only two are mapped
  typedef enum logic [3:0] {
    REG_SYS = 4'd0,
    REG_LA  = 4'd1
  } region_e;

  typedef enum logic [1:0] {LA_IDLE, LA_ARMED, LA_CAPTURE, LA_DONE} la_state_e;

  // Command field of LA_CTL
  typedef enum logic [1:0] {LA_CMD_NONE, LA_CMD_ARM, LA_CMD_SWTRG, LA_CMD_STOP} la_ctl_e;

  // Read value of an unmapped region
  localparam bus_data_t STUB_DATA = 32'hdead_beef;

  // System region word offsets
  localparam bus_off_t SYS_ID0     = 12'd0;
  localparam bus_off_t SYS_ID1     = 12'd1;
  localparam bus_off_t SYS_ID2     = 12'd2;
  localparam bus_off_t SYS_ID3     = 12'd3;
  localparam bus_off_t SYS_ID4     = 12'd4;
  localparam bus_off_t SYS_CTS_LO  = 12'd5;
  localparam bus_off_t SYS_CTS_HI  = 12'd6;
  localparam bus_off_t SYS_EXP_OUT = 12'd7;
  localparam bus_off_t SYS_LOOP    = 12'd8;

  // Analyzer region word offsets
  localparam bus_off_t LA_CTL   = 12'd0;
  localparam bus_off_t LA_MASK  = 12'd1;
  localparam bus_off_t LA_VALUE = 12'd2;
  localparam bus_off_t LA_TS_LO = 12'd3;
  localparam bus_off_t LA_TS_HI = 12'd4;
  localparam bus_off_t LA_BUF   = 12'd16;

endpackage

`default_nettype wire

// ==== logic/sys_bus_decoder.sv ====
/*
  Host bus region decoder
  Four-phase req/ack forwarding to the mapped slaves,
  stub answer for unmapped regions
*/
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder import la_sys_pkg::*; (
  input  wire       adc_clk,
  input  wire       top_rst,
  // Host side
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_addr_t bus_addr_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_ack_o,
  output bus_data_t bus_rdata_o,
  // Slave side
  output logic      sys_req_o,
  output logic      la_req_o,
  output logic      slv_we_o,
  output bus_off_t  slv_off_o,
  output bus_data_t slv_wdata_o,
  input  logic      sys_ack_i,
  input  logic      la_ack_i,
  input  bus_data_t sys_rdata_i,
  input  bus_data_t la_rdata_i
);

  // Region select bits at the top of the address
  localparam int unsigned RW = $clog2(REG_N);

  region_e   addr_reg;
  region_e   reg_q;
  logic      busy_q;
  logic      start;
  logic      slv_pend;
  logic      sel_ack;
  bus_data_t sel_rdata;

  assign addr_reg = region_e'(bus_addr_i[BUS_AW-1 -: RW]);

  // New request only once the previous one fully closed
  assign start    = bus_req_i && !busy_q;
  assign slv_pend = sys_req_o || la_req_o;

  // Answer of the latched region
  always_comb begin
    sel_ack   = 1'b0;
    sel_rdata = STUB_DATA;
    case (reg_q)
      REG_SYS: begin
        sel_ack   = sys_ack_i;
        sel_rdata = sys_rdata_i;
      end
      REG_LA: begin
        sel_ack   = la_ack_i;
        sel_rdata = la_rdata_i;
      end
      default: begin
        sel_ack   = 1'b0;
        sel_rdata = STUB_DATA;
      end
    endcase
  end

  ////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      busy_q    <= 1'b0;
      reg_q     <= REG_SYS;
      sys_req_o <= 1'b0;
      la_req_o  <= 1'b0;
      slv_we_o  <= 1'b0;
      bus_ack_o <= 1'b0;
    end else begin
      if (start) begin
        busy_q   <= 1'b1;
        reg_q    <= addr_reg;
        slv_we_o <= bus_we_i;
        case (addr_reg)
          REG_SYS: sys_req_o <= 1'b1;
          REG_LA:  la_req_o  <= 1'b1;
          // Unmapped, answer right away
          default: bus_ack_o <= 1'b1;
        endcase
      end else if (slv_pend && sel_ack) begin
        // Slave answered, release it and pass ack up
        sys_req_o <= 1'b0;
        la_req_o  <= 1'b0;
        bus_ack_o <= 1'b1;
      end else if (bus_ack_o && !bus_req_i && !sel_ack) begin
        // Host and slave both back to low
        bus_ack_o <= 1'b0;
        busy_q    <= 1'b0;
      end
    end
  end

  // Payload toward the slaves and read data toward the host
  always_ff @(posedge adc_clk) begin
    if (start) begin
      slv_off_o   <= bus_addr_i[BUS_AW-RW-1:2];
      slv_wdata_o <= bus_wdata_i;
      bus_rdata_o <= STUB_DATA;
    end else if (slv_pend && sel_ack) begin
      bus_rdata_o <= sel_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sys_regs.sv ====
/*
  Identification and control registers
  ID words, current time stamp with high-half shadow,
  expansion output and loopback sample select
*/
`timescale 1ns/1ns
`default_nettype none

module sys_regs import la_sys_pkg::*; #(
  parameter bit [0:5*32-1] GITH = '0
)(
  input  wire       adc_clk,
  input  wire       top_rst,
  // Slave bus
  input  logic      req_i,
  input  logic      we_i,
  input  bus_off_t  off_i,
  input  bus_data_t wdata_i,
  output logic      ack_o,
  output bus_data_t rdata_o,
  // Expansion connector
  input  smp_t      exp_p_i,
  output smp_t      exp_n_o,
  // Toward the analyzer
  output smp_t      smp_o,
  output ts_t       cts_o
);

  logic      acc;
  logic      loop_q;
  ts_t       cts_q;
  bus_data_t cts_hi_q;
  bus_data_t rd_val;

  // First cycle of a request
  assign acc = req_i && !ack_o;

  // Ack follows req by one edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req_i;
    end
  end

  // Free-running time stamp
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cts_q <= '0;
    end else begin
      cts_q <= cts_q + 1'b1;
    end
  end

  assign cts_o = cts_q;

  ////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      exp_n_o  <= '0;
      loop_q   <= 1'b0;
      cts_hi_q <= '0;
    end else if (acc) begin
      if (we_i) begin
        // ID words are read only
        case (off_i)
          SYS_EXP_OUT: exp_n_o <= wdata_i[SMP_W-1:0];
          SYS_LOOP:    loop_q  <= wdata_i[0];
          default:     ;
        endcase
      end else if (off_i == SYS_CTS_LO) begin
        // Freeze upper half for the next read
        cts_hi_q <= cts_q[TS_W-1:32];
      end
    end
  end

  // Read mux
  always_comb begin
    case (off_i)
      SYS_ID0:     rd_val = GITH[0*32 +: 32];
      SYS_ID1:     rd_val = GITH[1*32 +: 32];
      SYS_ID2:     rd_val = GITH[2*32 +: 32];
      SYS_ID3:     rd_val = GITH[3*32 +: 32];
      SYS_ID4:     rd_val = GITH[4*32 +: 32];
      SYS_CTS_LO:  rd_val = cts_q[31:0];
      SYS_CTS_HI:  rd_val = cts_hi_q;
      SYS_EXP_OUT: rd_val = bus_data_t'(exp_n_o);
      SYS_LOOP:    rd_val = bus_data_t'(loop_q);
      default:     rd_val = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (acc) begin
      rdata_o <= rd_val;
    end
  end

  // Loopback feeds own output back into the analyzer
  assign smp_o = loop_q ? exp_n_o : exp_p_i;

endmodule

`default_nettype wire

// ==== logic/la_acq.sv ====
/*
  Logic analyzer
  Masked pattern and software trigger, capture state machine,
  trigger time stamp and sample buffer read by the host
*/
`timescale 1ns/1ns
`default_nettype none

module la_acq import la_sys_pkg::*; #(
  parameter int unsigned LA_DEPTH = 16
)(
  input  wire       adc_clk,
  input  wire       top_rst,
  // Slave bus
  input  logic      req_i,
  input  logic      we_i,
  input  bus_off_t  off_i,
  input  bus_data_t wdata_i,
  output logic      ack_o,
  output bus_data_t rdata_o,
  // Sample stream and current time
  input  smp_t      smp_i,
  input  ts_t       cts_i,
  output logic      done_o
);

  // Buffer address width
  localparam int unsigned AW   = (LA_DEPTH > 1) ? $clog2(LA_DEPTH) : 1;
  localparam logic [AW-1:0] LAST = AW'(LA_DEPTH - 1);

  logic      acc;
  la_ctl_e   cmd;
  la_state_e state_q;
  smp_t      mask_q;
  smp_t      value_q;
  ts_t       trg_ts_q;
  logic [AW-1:0] wptr_q;
  logic      trg_hit;
  logic      fire;
  logic      wr_en;
  bus_off_t  buf_off;
  logic      buf_hit;
  bus_data_t rd_val;

  // Sample memory
  smp_t buf_mem [LA_DEPTH];

  assign acc = req_i && !ack_o;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req_i;
    end
  end

  // Command strobe from a write to LA_CTL
  always_comb begin
    cmd = LA_CMD_NONE;
    if (acc && we_i && off_i == LA_CTL) begin
      cmd = la_ctl_e'(wdata_i[1:0]);
    end
  end

  ////////////////////////////////////////
  // Trigger
  ////////////////////////////////////////

  // Only masked bits compare, mask 0 always hits
  assign trg_hit = ((smp_i ^ value_q) & mask_q) == '0;
  assign fire    = (state_q == LA_ARMED) && (trg_hit || cmd == LA_CMD_SWTRG);

  // Trigger sample lands in word 0
  assign wr_en = fire || (state_q == LA_CAPTURE);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mask_q  <= '0;
      value_q <= '0;
    end else if (acc && we_i) begin
      case (off_i)
        LA_MASK:  mask_q  <= wdata_i[SMP_W-1:0];
        LA_VALUE: value_q <= wdata_i[SMP_W-1:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Capture FSM
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q  <= LA_IDLE;
      wptr_q   <= '0;
      trg_ts_q <= '0;
    end else if (cmd == LA_CMD_STOP) begin
      state_q <= LA_IDLE;
    end else if (cmd == LA_CMD_ARM) begin
      // Re-arm from any state
      state_q <= LA_ARMED;
      wptr_q  <= '0;
    end else begin
      case (state_q)
        LA_ARMED: begin
          if (fire) begin
            state_q  <= LA_CAPTURE;
            trg_ts_q <= cts_i;
            wptr_q   <= wptr_q + 1'b1;
          end
        end
        LA_CAPTURE: begin
          wptr_q <= wptr_q + 1'b1;
          // Last word written this cycle
          if (wptr_q == LAST) begin
            state_q <= LA_DONE;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      buf_mem[wptr_q] <= smp_i;
    end
  end

  assign done_o = (state_q == LA_DONE);

  ////////////////////////////////////////
  // Register read
  ////////////////////////////////////////

  assign buf_off = off_i - LA_BUF;
  assign buf_hit = (off_i >= LA_BUF) && (buf_off < LA_DEPTH);

  always_comb begin
    case (off_i)
      LA_CTL:   rd_val = bus_data_t'(state_q);
      LA_MASK:  rd_val = bus_data_t'(mask_q);
      LA_VALUE: rd_val = bus_data_t'(value_q);
      LA_TS_LO: rd_val = trg_ts_q[31:0];
      LA_TS_HI: rd_val = trg_ts_q[TS_W-1:32];
      default: begin
        // Buffer window, anything else reads zero
        rd_val = buf_hit ? bus_data_t'(buf_mem[buf_off[AW-1:0]]) : '0;
      end
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (acc) begin
      rdata_o <= rd_val;
    end
  end

endmodule

`default_nettype wire

// ==== logic/la_sys_top.sv ====
/*
  Top level of the slow domain
  Bus decoder, system registers and logic analyzer
*/
`timescale 1ns/1ns
`default_nettype none

module la_sys_top import la_sys_pkg::*; #(
  // Build identification, five words
  parameter bit [0:5*32-1] GITH     = '0,
  // Stored samples per capture
  parameter int unsigned   LA_DEPTH = 16
)(
  input  wire       adc_clk,
  input  wire       top_rst,
  // Host bus
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_addr_t bus_addr_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_ack_o,
  output bus_data_t bus_rdata_o,
  // Expansion connector
  input  smp_t      exp_p_i,
  output smp_t      exp_n_o,
  // Capture finished
  output logic      la_done_o
);

  ////////////////////////////////////////
  // Local wires
  ////////////////////////////////////////

  // Requests toward the slaves
  logic      sys_req;
  logic      la_req;
  // Shared slave payload
  logic      slv_we;
  bus_off_t  slv_off;
  bus_data_t slv_wdata;
  // Slave answers
  logic      sys_ack;
  logic      la_ack;
  bus_data_t sys_rdata;
  bus_data_t la_rdata;
  // Sample stream and time stamp
  smp_t      smp;
  ts_t       cts;

  ////////////////////////////////////////
  // Bus decoder
  ////////////////////////////////////////

  sys_bus_decoder u_dec (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_ack_o   (bus_ack_o),
    .bus_rdata_o (bus_rdata_o),
    .sys_req_o   (sys_req),
    .la_req_o    (la_req),
    .slv_we_o    (slv_we),
    .slv_off_o   (slv_off),
    .slv_wdata_o (slv_wdata),
    .sys_ack_i   (sys_ack),
    .la_ack_i    (la_ack),
    .sys_rdata_i (sys_rdata),
    .la_rdata_i  (la_rdata)
  );

  // Region 0, identification and control
  sys_regs #(
    .GITH (GITH)
  ) u_sys (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (sys_req),
    .we_i    (slv_we),
    .off_i   (slv_off),
    .wdata_i (slv_wdata),
    .ack_o   (sys_ack),
    .rdata_o (sys_rdata),
    .exp_p_i (exp_p_i),
    .exp_n_o (exp_n_o),
    .smp_o   (smp),
    .cts_o   (cts)
  );

  // Region 1, logic analyzer
  la_acq #(
    .LA_DEPTH (LA_DEPTH)
  ) u_la (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (la_req),
    .we_i    (slv_we),
    .off_i   (slv_off),
    .wdata_i (slv_wdata),
    .ack_o   (la_ack),
    .rdata_o (la_rdata),
    .smp_i   (smp),
    .cts_i   (cts),
    .done_o  (la_done_o)
  );

endmodule

`default_nettype wire

// ==== dv/la_sys_asserts.sv ====
/*
  Host bus handshake checks on the region decoder
  Ack rise and fall against req, read data held during ack
*/
`timescale 1ns/1ns
`default_nettype none

module la_sys_asserts import la_sys_pkg::*; (
  input wire       adc_clk,
  input wire       top_rst,
  input logic      bus_req_i,
  input logic      bus_ack_i,
  input bus_data_t bus_rdata_i
);

  // Number of handshake rule violations
  int unsigned fail_cnt = 0;

  // Ack may only come up for a pending request
  ack_rise_with_req: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    $rose(bus_ack_i) |-> bus_req_i
  ) else begin
    $error("bus ack rose without a request");
    fail_cnt++;
  end

  // Phase four follows the host dropping req
  ack_fall_after_req: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    $fell(bus_ack_i) |-> $past(!bus_req_i)
  ) else begin
    $error("bus ack fell while req was still high");
    fail_cnt++;
  end

  // Host may sample rdata at any point of the ack phase
  rdata_held: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (bus_ack_i && $past(bus_ack_i)) |-> $stable(bus_rdata_i)
  ) else begin
    $error("bus rdata changed while ack was high");
    fail_cnt++;
  end

endmodule

bind sys_bus_decoder la_sys_asserts u_bus_asserts (
  .adc_clk     (adc_clk),
  .top_rst     (top_rst),
  .bus_req_i   (bus_req_i),
  .bus_ack_i   (bus_ack_o),
  .bus_rdata_i (bus_rdata_o)
);

`default_nettype wire

// ==== dv/la_sys_tb.sv ====
/*
  Testbench of the slow-domain top level
  Clock, reset, host bus tasks, xorshift source, compare tasks,
  table of ID accesses and the analyzer scenarios
*/
`timescale 1ns/1ns
`default_nettype none

module la_sys_tb
  import la_sys_pkg::*;
();

  localparam int unsigned DEPTH    = 16;
  localparam int unsigned ACK_TMO  = 50;
  localparam int unsigned DONE_TMO = 2000;
  // Five ID words, word 0 leftmost
  localparam bit [0:5*32-1] ID_WORDS =
    160'h0123_4567_89ab_cdef_1357_9bdf_2468_ace0_0f1e_2d3c;

  // One table step, a single bus access
  typedef enum logic {OP_RD, OP_WR} op_e;
  typedef enum logic {CHK_NONE, CHK_DATA} chk_e;
  typedef struct packed {
    op_e       op;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t exp;
    chk_e      chk;
  } bus_step_t;

  logic        adc_clk;
  logic        top_rst;
  logic        bus_req_i;
  logic        bus_we_i;
  bus_addr_t   bus_addr_i;
  bus_data_t   bus_wdata_i;
  logic        bus_ack_o;
  bus_data_t   bus_rdata_o;
  smp_t        exp_p_i = '0;
  smp_t        exp_n_o;
  logic        la_done_o;

  bus_step_t   id_tab[$];
  logic [31:0] rng_q;
  int unsigned err_cnt;
  int unsigned chk_cnt;
  int unsigned test_cnt;
  int unsigned bad_tests;
  // Handshake rule violations seen by the bound checker
  int unsigned sva_errs;

  la_sys_top #(
    .GITH     (ID_WORDS),
    .LA_DEPTH (DEPTH)
  ) dut_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_ack_o   (bus_ack_o),
    .bus_rdata_o (bus_rdata_o),
    .exp_p_i     (exp_p_i),
    .exp_n_o     (exp_n_o),
    .la_done_o   (la_done_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  // Expansion inputs ramp once reset is gone
  always @(posedge adc_clk) begin
    if (top_rst) begin
      exp_p_i <= '0;
    end else begin
      exp_p_i <= exp_p_i + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Region in the top 4 bits, word index above the byte lanes
  function automatic bus_addr_t reg_addr(input logic [3:0] region, input bus_off_t off);
    return {region, off, 2'b00};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_rand(output bus_data_t v);
    rng_q = xorshift32(rng_q);
    v = rng_q;
  endtask

  task automatic fail_run(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("tests failed");
    $finish;
  endtask

  // Full four-phase cycle, outputs sampled on the falling edge
  task automatic bus_xfer(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                          output bus_data_t rdata);
    int unsigned n;
    @(posedge adc_clk);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    n = 0;
    @(negedge adc_clk);
    while (!bus_ack_o) begin
      if (n == ACK_TMO) fail_run("bus ack never rose");
      n++;
      @(negedge adc_clk);
    end
    rdata = bus_rdata_o;
    @(posedge adc_clk);
    bus_req_i <= 1'b0;
    bus_we_i  <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (bus_ack_o) begin
      if (n == ACK_TMO) fail_run("bus ack never fell");
      n++;
      @(negedge adc_clk);
    end
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
    bus_data_t unused;
    bus_xfer(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
    bus_xfer(1'b0, addr, '0, data);
  endtask

  // Low word first, it freezes the high half
  task automatic read_stamp(input bus_addr_t lo, input bus_addr_t hi, output ts_t ts);
    bus_data_t lo_w;
    bus_data_t hi_w;
    read_reg(lo, lo_w);
    read_reg(hi, hi_w);
    ts = {hi_w, lo_w};
  endtask

  task automatic wait_done();
    int unsigned n;
    n = 0;
    @(negedge adc_clk);
    while (!la_done_o) begin
      if (n == DONE_TMO) fail_run("la_done_o never rose");
      n++;
      @(negedge adc_clk);
    end
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_smp(input string what, input smp_t got, input smp_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Time stamps are checked against a window
  task automatic check_ts(input string what, input ts_t got, input ts_t lo, input ts_t hi);
    chk_cnt++;
    if ($isunknown(got) || got < lo || got > hi) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %h outside %h..%h", $time, what, got, lo, hi);
    end
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      bad_tests++;
      $display("test %0d %s: FAIL, %0d mismatches", test_cnt, name, err_cnt - err_before);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // ID words, ignored writes, stub regions, reset values
  task automatic load_id_table();
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID0), '0, 32'h0123_4567, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID1), '0, 32'h89ab_cdef, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID2), '0, 32'h1357_9bdf, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID3), '0, 32'h2468_ace0, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID4), '0, 32'h0f1e_2d3c, CHK_DATA});
    id_tab.push_back('{OP_WR, reg_addr(REG_SYS, SYS_ID2), 32'h5555_aaaa, '0, CHK_NONE});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID2), '0, 32'h1357_9bdf, CHK_DATA});
    id_tab.push_back('{OP_WR, reg_addr(REG_SYS, SYS_ID4), 32'hffff_ffff, '0, CHK_NONE});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_ID4), '0, 32'h0f1e_2d3c, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(4'd9, 12'd3), '0, STUB_DATA, CHK_DATA});
    id_tab.push_back('{OP_WR, reg_addr(4'd15, 12'd0), 32'h1234_5678, '0, CHK_NONE});
    id_tab.push_back('{OP_RD, reg_addr(4'd15, 12'd0), '0, STUB_DATA, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_LA, LA_CTL), '0, bus_data_t'(LA_IDLE), CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_LOOP), '0, '0, CHK_DATA});
    id_tab.push_back('{OP_RD, reg_addr(REG_SYS, SYS_EXP_OUT), '0, '0, CHK_DATA});
  endtask

  task automatic test_ident();
    bus_data_t   rd;
    int unsigned e0;
    e0 = err_cnt;
    foreach (id_tab[i]) begin
      if (id_tab[i].op == OP_WR) begin
        write_reg(id_tab[i].addr, id_tab[i].wdata);
      end else begin
        read_reg(id_tab[i].addr, rd);
        if (id_tab[i].chk == CHK_DATA) begin
          check_data($sformatf("table step %0d", i), rd, id_tab[i].exp);
        end
      end
    end
    check_smp("exp_n_o after reset", exp_n_o, '0);
    check_data("la_done_o after reset", bus_data_t'(la_done_o), '0);
    end_test("identification", e0);
  endtask

  task automatic test_time_stamp();
    ts_t         t1;
    ts_t         t2;
    int unsigned e0;
    e0 = err_cnt;
    read_stamp(reg_addr(REG_SYS, SYS_CTS_LO), reg_addr(REG_SYS, SYS_CTS_HI), t1);
    read_stamp(reg_addr(REG_SYS, SYS_CTS_LO), reg_addr(REG_SYS, SYS_CTS_HI), t2);
    check_ts("second time stamp", t2, t1 + 64'd1, '1);
    end_test("time stamp", e0);
  endtask

  task automatic test_exp_out();
    bus_data_t   w;
    bus_data_t   rd;
    int unsigned e0;
    e0 = err_cnt;
    repeat (4) begin
      draw_rand(w);
      write_reg(reg_addr(REG_SYS, SYS_EXP_OUT), w);
      check_smp("exp_n_o pins", exp_n_o, w[SMP_W-1:0]);
      read_reg(reg_addr(REG_SYS, SYS_EXP_OUT), rd);
      check_data("SYS_EXP_OUT read back", rd, bus_data_t'(w[SMP_W-1:0]));
    end
    end_test("expansion output", e0);
  endtask

  // Ramp input, so word k holds V + k
  task automatic test_pattern_trigger();
    bus_data_t   r;
    smp_t        v;
    ts_t         t_before;
    ts_t         t_after;
    ts_t         t_trg;
    int unsigned k;
    int unsigned e0;
    e0 = err_cnt;
    draw_rand(r);
    v = r[SMP_W-1:0];
    write_reg(reg_addr(REG_LA, LA_MASK), 32'h0000_00ff);
    write_reg(reg_addr(REG_LA, LA_VALUE), bus_data_t'(v));
    read_stamp(reg_addr(REG_SYS, SYS_CTS_LO), reg_addr(REG_SYS, SYS_CTS_HI), t_before);
    write_reg(reg_addr(REG_LA, LA_CTL), bus_data_t'(LA_CMD_ARM));
    wait_done();
    read_stamp(reg_addr(REG_SYS, SYS_CTS_LO), reg_addr(REG_SYS, SYS_CTS_HI), t_after);
    read_stamp(reg_addr(REG_LA, LA_TS_LO), reg_addr(REG_LA, LA_TS_HI), t_trg);
    check_ts("trigger time stamp", t_trg, t_before, t_after);
    for (k = 0; k < DEPTH; k++) begin
      read_reg(reg_addr(REG_LA, bus_off_t'(LA_BUF + k)), r);
      check_smp($sformatf("buffer word %0d", k), r[SMP_W-1:0], smp_t'(v + k));
    end
    end_test("pattern trigger", e0);
  endtask

  // Constant looped sample W never matches ~W
  task automatic test_loop_swtrg();
    bus_data_t   r;
    smp_t        w;
    int unsigned k;
    int unsigned e0;
    e0 = err_cnt;
    draw_rand(r);
    w = r[SMP_W-1:0];
    write_reg(reg_addr(REG_SYS, SYS_EXP_OUT), bus_data_t'(w));
    write_reg(reg_addr(REG_SYS, SYS_LOOP), 32'd1);
    write_reg(reg_addr(REG_LA, LA_MASK), 32'h0000_00ff);
    write_reg(reg_addr(REG_LA, LA_VALUE), bus_data_t'(~w));
    write_reg(reg_addr(REG_LA, LA_CTL), bus_data_t'(LA_CMD_ARM));
    read_reg(reg_addr(REG_LA, LA_CTL), r);
    check_data("state after arm", r, bus_data_t'(LA_ARMED));
    write_reg(reg_addr(REG_LA, LA_CTL), bus_data_t'(LA_CMD_SWTRG));
    wait_done();
    for (k = 0; k < DEPTH; k++) begin
      read_reg(reg_addr(REG_LA, bus_off_t'(LA_BUF + k)), r);
      check_smp($sformatf("looped word %0d", k), r[SMP_W-1:0], w);
    end
    write_reg(reg_addr(REG_LA, LA_CTL), bus_data_t'(LA_CMD_STOP));
    read_reg(reg_addr(REG_LA, LA_CTL), r);
    check_data("state after stop", r, bus_data_t'(LA_IDLE));
    check_data("la_done_o after stop", bus_data_t'(la_done_o), '0);
    write_reg(reg_addr(REG_SYS, SYS_LOOP), 32'd0);
    end_test("loopback software trigger", e0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    top_rst     = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    rng_q       = 32'h970a_a371;
    err_cnt     = 0;
    chk_cnt     = 0;
    test_cnt    = 0;
    bad_tests   = 0;
    sva_errs    = 0;
    load_id_table();
    repeat (5) @(posedge adc_clk);
    top_rst <= 1'b0;
    test_ident();
    test_time_stamp();
    test_exp_out();
    test_pattern_trigger();
    test_loop_swtrg();
    sva_errs = dut_i.u_dec.u_bus_asserts.fail_cnt;
    $display("%0d tests, %0d with errors, %0d checks, %0d mismatches, %0d assertion errors",
             test_cnt, bad_tests, chk_cnt, err_cnt, sva_errs);
    if (err_cnt == 0 && sva_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/la_sys_pkg.sv
logic/sys_bus_decoder.sv
logic/sys_regs.sv
logic/la_acq.sv
logic/la_sys_top.sv
dv/la_sys_asserts.sv
dv/la_sys_tb.sv

// ==== Makefile ====
# Verilator build and run of the slow-domain testbench
VERILATOR ?= verilator
TOP       ?= la_sys_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
